// File: common/mips_defs.svh
// Sizing constants for the single-cycle MIPS core.
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and address width in bits.
`define MIPS_XLEN 32

// Architectural register count, register 0 reads as zero.
`define MIPS_NREGS 32

// Data memory depth in 32-bit words.
`define MIPS_DMEM_WORDS 256

// Fetch address taken when reset is released.
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: common/mipsPkg.sv
// MIPS subset package with the instruction word views and the decoder encodings.
`default_nettype none

package mipsPkg;

  // Register-format view of the instruction word.
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rTypeT;

  // Immediate-format view, used by lw, sw and beq.
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iTypeT;

  typedef union packed {
    rTypeT r;
    iTypeT i;
  } instrT;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011,
    OP_BEQ   = 6'b000100
  } opcodeT;

  typedef enum logic [5:0] {
    FUNCT_ADD = 6'b100000,
    FUNCT_SUB = 6'b100010,
    FUNCT_AND = 6'b100100,
    FUNCT_OR  = 6'b100101,
    FUNCT_SLT = 6'b101010
  } functT;

  typedef enum logic [1:0] {
    ALUOP_MEMADD = 2'b00, // Address add for loads and stores.
    ALUOP_BRSUB  = 2'b01, // Subtract for the beq compare.
    ALUOP_RFUNCT = 2'b10
  } aluOpT;

  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } aluCtrlT;

endpackage

`default_nettype wire

// File: control/mainDecoder.sv
// Main decoder turning the opcode into datapath strobes and the ALU operation class.
`timescale 1ns/1ps
`default_nettype none

module mainDecoder (
  input  wire mipsPkg::opcodeT opcode,
  output logic                 regWrite,
  output logic                 regDst,
  output logic                 aluSrc,
  output logic                 branch,
  output logic                 memWrite,
  output logic                 memToReg,
  output mipsPkg::aluOpT       aluOp
);

  always_comb begin
    // Anything outside the subset falls through as a no-op.
    regWrite = 1'b0;
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    branch   = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    aluOp    = mipsPkg::ALUOP_MEMADD;

    case (opcode)
      mipsPkg::OP_RTYPE: begin
        regWrite = 1'b1;
        regDst   = 1'b1; // Result goes to rd.
        aluOp    = mipsPkg::ALUOP_RFUNCT;
      end
      mipsPkg::OP_LW: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        memToReg = 1'b1;
      end
      mipsPkg::OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::OP_BEQ: begin
        branch = 1'b1;
        aluOp  = mipsPkg::ALUOP_BRSUB; // Zero flag carries the compare.
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: control/aluDecoder.sv
// ALU decoder mapping the operation class and funct field to an ALU operation.
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
  input  wire mipsPkg::aluOpT  aluOp,
  input  wire mipsPkg::functT  funct,
  output mipsPkg::aluCtrlT     aluCtrl
);

  always_comb begin
    aluCtrl = mipsPkg::ALU_ADD;

    case (aluOp)
      mipsPkg::ALUOP_MEMADD: aluCtrl = mipsPkg::ALU_ADD;
      mipsPkg::ALUOP_BRSUB:  aluCtrl = mipsPkg::ALU_SUB;
      mipsPkg::ALUOP_RFUNCT: begin
        case (funct)
          mipsPkg::FUNCT_ADD: aluCtrl = mipsPkg::ALU_ADD;
          mipsPkg::FUNCT_SUB: aluCtrl = mipsPkg::ALU_SUB;
          mipsPkg::FUNCT_AND: aluCtrl = mipsPkg::ALU_AND;
          mipsPkg::FUNCT_OR:  aluCtrl = mipsPkg::ALU_OR;
          mipsPkg::FUNCT_SLT: aluCtrl = mipsPkg::ALU_SLT;
          // Unknown funct codes behave as add.
          default:            aluCtrl = mipsPkg::ALU_ADD;
        endcase
      end
      default: aluCtrl = mipsPkg::ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

// File: design/regFile.sv
// Register file with two combinational read ports and one clocked write port.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module regFile (
  input  wire logic                  clk,
  input  wire logic                  arstN,
  input  wire logic                  regWrite,
  input  wire logic                  regDst,
  input  wire mipsPkg::instrT        instr,
  input  wire logic [`MIPS_XLEN-1:0] result,
  output logic      [`MIPS_XLEN-1:0] rsData,
  output logic      [`MIPS_XLEN-1:0] rtData
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];
  logic [4:0]            wrAddr;

  // R-type writes rd, loads write rt.
  assign wrAddr = regDst ? instr.r.rd : instr.i.rt;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= result; // Register 0 is never written.
    end
  end

  assign rsData = regs[instr.r.rs];
  assign rtData = regs[instr.r.rt];

endmodule

`default_nettype wire

// File: design/execUnit.sv
// Execution unit with sign extension, operand select, the ALU and its zero flag.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module execUnit (
  input  wire mipsPkg::instrT        instr,
  input  wire logic                  aluSrc,
  input  wire mipsPkg::aluCtrlT      aluCtrl,
  input  wire logic [`MIPS_XLEN-1:0] rsData,
  input  wire logic [`MIPS_XLEN-1:0] rtData,
  output logic      [`MIPS_XLEN-1:0] aluResult,
  output logic                       zero
);

  logic [`MIPS_XLEN-1:0] signImm;
  logic [`MIPS_XLEN-1:0] srcB;

  assign signImm = {{(`MIPS_XLEN-16){instr.i.imm[15]}}, instr.i.imm};
  assign srcB    = aluSrc ? signImm : rtData; // Immediate for lw and sw.

  always_comb begin
    case (aluCtrl)
      mipsPkg::ALU_AND: aluResult = rsData & srcB;
      mipsPkg::ALU_OR:  aluResult = rsData | srcB;
      mipsPkg::ALU_ADD: aluResult = rsData + srcB;
      mipsPkg::ALU_SUB: aluResult = rsData - srcB;
      mipsPkg::ALU_SLT: begin
        // Signed compare, so a negative rs is below a positive operand.
        aluResult = {{(`MIPS_XLEN-1){1'b0}}, ($signed(rsData) < $signed(srcB))};
      end
      default:          aluResult = rsData + srcB;
    endcase
  end

  assign zero = (aluResult == '0);

endmodule

`default_nettype wire

// File: design/fetchUnit.sv
// Fetch unit holding the program counter and choosing the next fetch address.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module fetchUnit (
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire mipsPkg::instrT   instr,
  input  wire logic             branch,
  input  wire logic             zero,
  output logic [`MIPS_XLEN-1:0] pc
);

  logic [`MIPS_XLEN-1:0] pcPlus4;
  logic [`MIPS_XLEN-1:0] brOffset;
  logic [`MIPS_XLEN-1:0] pcNext;
  logic                  brTaken;

  assign pcPlus4  = pc + `MIPS_XLEN'(4);
  assign brOffset = {{(`MIPS_XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00}; // Word offset.
  assign brTaken  = branch & zero;

  // Branch target is relative to the following instruction.
  assign pcNext = brTaken ? (pcPlus4 + brOffset) : pcPlus4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// File: design/memStage.sv
// Data memory with clocked stores, combinational loads and the writeback select.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module memStage (
  input  wire logic                  clk,
  input  wire logic                  memWrite,
  input  wire logic                  memToReg,
  input  wire logic [`MIPS_XLEN-1:0] aluResult,
  input  wire logic [`MIPS_XLEN-1:0] rtData,
  output logic      [`MIPS_XLEN-1:0] result
);

  localparam int AddrBits = $clog2(`MIPS_DMEM_WORDS);

  logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_WORDS];
  logic [AddrBits-1:0]   wordAddr;
  logic [`MIPS_XLEN-1:0] loadData;

  // The two low address bits are the byte offset and are ignored.
  assign wordAddr = aluResult[AddrBits+1:2];

  always_ff @(posedge clk) begin
    if (memWrite) begin
      mem[wordAddr] <= rtData;
    end
  end

  assign loadData = mem[wordAddr];
  assign result   = memToReg ? loadData : aluResult; // Load data only for lw.

endmodule

`default_nettype wire

// File: design/mipsCore.sv
// Single-cycle MIPS subset core joining the decoders, fetch, registers, ALU and memory.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module mipsCore (
  input  wire logic                  clk,
  input  wire logic                  arstN,
  input  wire logic [`MIPS_XLEN-1:0] instr,
  output logic      [`MIPS_XLEN-1:0] pc,
  output logic                       memWrite,
  output logic      [`MIPS_XLEN-1:0] dataAddr,
  output logic      [`MIPS_XLEN-1:0] writeData
);

  mipsPkg::instrT   instrU;
  mipsPkg::opcodeT  opcode;
  mipsPkg::functT   funct;
  mipsPkg::aluOpT   aluOp;
  mipsPkg::aluCtrlT aluCtrl;

  logic                  regWrite;
  logic                  regDst;
  logic                  aluSrc;
  logic                  branch;
  logic                  memToReg;
  logic                  zero;
  logic [`MIPS_XLEN-1:0] rsData;
  logic [`MIPS_XLEN-1:0] rtData;
  logic [`MIPS_XLEN-1:0] aluResult;
  logic [`MIPS_XLEN-1:0] result;

  assign instrU = instr;
  assign opcode = mipsPkg::opcodeT'(instrU.r.opcode); // Undefined codes decode as no-ops.
  assign funct  = mipsPkg::functT'(instrU.r.funct);

  mainDecoder mainDecoder_i (
    .opcode  (opcode),
    .regWrite(regWrite),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .branch  (branch),
    .memWrite(memWrite),
    .memToReg(memToReg),
    .aluOp   (aluOp)
  );

  aluDecoder aluDecoder_i (.aluOp(aluOp), .funct(funct), .aluCtrl(aluCtrl));

  fetchUnit fetchUnit_i (
    .clk   (clk),
    .arstN (arstN),
    .instr (instrU),
    .branch(branch),
    .zero  (zero),
    .pc    (pc)
  );

  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .regWrite(regWrite),
    .regDst  (regDst),
    .instr   (instrU),
    .result  (result),
    .rsData  (rsData),
    .rtData  (rtData)
  );

  execUnit execUnit_i (
    .instr    (instrU),
    .aluSrc   (aluSrc),
    .aluCtrl  (aluCtrl),
    .rsData   (rsData),
    .rtData   (rtData),
    .aluResult(aluResult),
    .zero     (zero)
  );

  memStage memStage_i (
    .clk      (clk),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .aluResult(aluResult),
    .rtData   (rtData),
    .result   (result)
  );

  // Store traffic is visible at the top for the testbench.
  assign dataAddr  = aluResult;
  assign writeData = rtData;

endmodule

`default_nettype wire

// File: dv/mipsRefModel.svh
// Instruction-set reference model of the MIPS subset, stepping the architectural state once.
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// Returns the next PC. Registers and memory change in place and a store is reported.
function automatic logic [31:0] stepModel(
  input  logic [31:0]                       word,
  input  logic [31:0]                       curPc,
  inout  logic [`MIPS_NREGS-1:0][31:0]      regs,
  inout  logic [`MIPS_DMEM_WORDS-1:0][31:0] mem,
  output logic                              storeEn,
  output logic [31:0]                       storeAddr,
  output logic [31:0]                       storeData
);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] offset;
  logic [31:0] addr;
  logic [31:0] value;
  logic [31:0] nextPc;

  a         = regs[word[25:21]];
  b         = regs[word[20:16]];
  offset    = {{16{word[15]}}, word[15:0]};
  addr      = a + offset;
  nextPc    = curPc + 32'd4;
  storeEn   = 1'b0;
  storeAddr = '0;
  storeData = '0;

  case (word[31:26])
    mipsPkg::OP_RTYPE: begin
      case (word[5:0])
        mipsPkg::FUNCT_SUB: value = a - b;
        mipsPkg::FUNCT_AND: value = a & b;
        mipsPkg::FUNCT_OR:  value = a | b;
        mipsPkg::FUNCT_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:            value = a + b; // Add, and any funct outside the subset.
      endcase
      if (word[15:11] != 5'd0) begin
        regs[word[15:11]] = value;
      end
    end
    mipsPkg::OP_LW: begin
      if (word[20:16] != 5'd0) begin
        regs[word[20:16]] = mem[addr[9:2]]; // The byte offset is dropped.
      end
    end
    mipsPkg::OP_SW: begin
      storeEn        = 1'b1;
      storeAddr      = addr;
      storeData      = b;
      mem[addr[9:2]] = b;
    end
    mipsPkg::OP_BEQ: begin
      if (a == b) begin
        nextPc = curPc + 32'd4 + {offset[29:0], 2'b00};
      end
    end
    default: ; // Other opcodes only advance the PC.
  endcase
  return nextPc;
endfunction

`endif

// File: dv/tbMipsCore.sv
// Testbench for the single-cycle MIPS core, checked instruction by instruction against a model.
`timescale 1ns/1ps
`default_nettype none
`include "mips_defs.svh"

module tbMipsCore;

  localparam logic [31:0] NopWord = 32'hFC00_0000; // Opcode 6'b111111 is not in the subset.

  logic        clk = 1'b0;
  logic        arstN;
  logic        memWrite;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] dataAddr;
  logic [31:0] writeData;

  logic [31:0]                       prog [$];
  logic [`MIPS_NREGS-1:0][31:0]      modelRegs;
  logic [`MIPS_DMEM_WORDS-1:0][31:0] modelMem;
  logic [31:0]                       modelPc;
  logic [31:0]                       nextPc;
  logic                              stEn;
  logic [31:0]                       stAddr;
  logic [31:0]                       stData;
  logic                              done = 1'b0;
  int                                cycles = 0;
  int                                cycleLimit = 0;
  integer                            seed = 32'h87c3e41c;

  `include "mipsRefModel.svh"

  mipsCore mipsCore_i (
    .clk      (clk),
    .arstN    (arstN),
    .instr    (instr),
    .pc       (pc),
    .memWrite (memWrite),
    .dataAddr (dataAddr),
    .writeData(writeData)
  );

  always #4 clk = ~clk;

  task automatic pushR(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
    prog.push_back({mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn});
  endtask

  task automatic pushI(input logic [5:0] op, input logic [4:0] rs, rt, input logic [15:0] imm);
    prog.push_back({op, rs, rt, imm});
  endtask

  // Preloaded data memory. Every index bit shapes the word, and low indexes give negatives.
  function automatic logic [31:0] fillWord(input logic [7:0] idx);
    return {idx ^ 8'hA5, ~idx, idx * 8'd37, idx ^ 8'h3C};
  endfunction

  function automatic logic [31:0] fetchWord(input logic [31:0] addr);
    if ((addr >> 2) < prog.size()) begin
      return prog[addr >> 2];
    end else begin
      return NopWord;
    end
  endfunction

  function automatic logic [5:0] functFor(input int k);
    case (k)
      0:       return mipsPkg::FUNCT_ADD;
      1:       return mipsPkg::FUNCT_SUB;
      2:       return mipsPkg::FUNCT_AND;
      3:       return mipsPkg::FUNCT_OR;
      default: return mipsPkg::FUNCT_SLT;
    endcase
  endfunction

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic buildProgram();
    logic [31:0] r;
    pushI(mipsPkg::OP_LW, 5'd0, 5'd1, 16'h0000);
    pushI(mipsPkg::OP_LW, 5'd0, 5'd2, 16'h0204);
    pushI(mipsPkg::OP_LW, 5'd0, 5'd3, 16'h0010);
    pushI(mipsPkg::OP_LW, 5'd0, 5'd4, 16'h03FC);
    for (int k = 0; k < 5; k++) begin
      pushR(5'd1, 5'd2, 5'd5, functFor(k)); // Negative rs against positive rt.
      pushI(mipsPkg::OP_SW, 5'd0, 5'd5, 16'h0100 + 16'(4 * k));
    end
    pushR(5'd2, 5'd1, 5'd6, mipsPkg::FUNCT_SLT);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd6, 16'h0114);
    pushR(5'd3, 5'd1, 5'd7, mipsPkg::FUNCT_SLT); // Both operands negative.
    pushI(mipsPkg::OP_SW, 5'd0, 5'd7, 16'h0118);
    // Round trip through memory. The second one uses a negative offset.
    pushI(mipsPkg::OP_SW, 5'd0, 5'd1, 16'h0120);
    pushI(mipsPkg::OP_LW, 5'd0, 5'd8, 16'h0120);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd8, 16'h0124);
    pushI(mipsPkg::OP_SW, 5'd4, 5'd2, 16'hFFF8);
    pushI(mipsPkg::OP_LW, 5'd4, 5'd9, 16'hFFF8);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd9, 16'h0128);
    // Forward taken, not taken, backward taken, then forward past the loop.
    pushI(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'd2);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd1, 16'h012C);
    pushI(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'd2);
    pushI(mipsPkg::OP_BEQ, 5'd1, 5'd2, 16'd5);
    pushI(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'hFFFD);
    pushR(5'd1, 5'd2, 5'd0, mipsPkg::FUNCT_ADD);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd0, 16'h0130);
    pushI(6'b100000, 5'd0, 5'd5, 16'h0000); // A byte load, which the core treats as a no-op.
    pushI(mipsPkg::OP_SW, 5'd0, 5'd5, 16'h0134);
    pushR(5'd1, 5'd2, 5'd10, 6'b100001);
    pushI(mipsPkg::OP_SW, 5'd0, 5'd10, 16'h0138);
    for (int k = 0; k < 200; k++) begin
      r = $random(seed);
      pushR(5'd1 + 5'(r[7:0] % 7), 5'd1 + 5'(r[15:8] % 7), 5'd1 + 5'(r[23:16] % 7),
            functFor(r[31:24] % 5));
      r = $random(seed);
      if (r[8]) begin
        pushI(mipsPkg::OP_SW, 5'd0, 5'd1 + 5'(r[7:0] % 7), 16'h0300 + {10'd0, r[13:10], 2'b00});
      end
    end
  endtask

  initial begin
    arstN = 1'b1;
    instr = NopWord;
    buildProgram();
    cycleLimit = prog.size() * 2 + 64;
    modelPc    = `MIPS_RESET_PC;
    modelRegs  = '0;
    for (int i = 0; i < `MIPS_DMEM_WORDS; i++) begin
      modelMem[i]                  = fillWord(i[7:0]);
      mipsCore_i.memStage_i.mem[i] = fillWord(i[7:0]);
    end
    #1;
    arstN = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    arstN = 1'b1;
    instr = fetchWord(pc);
    wait (done);
    $display(">>> PASS");
    $finish;
  end

  // Instruction ROM output follows the new pc shortly after each edge.
  always @(posedge clk) begin
    #1;
    if (arstN) begin
      instr = fetchWord(pc);
    end
  end

  always @(posedge clk) begin
    if (!arstN) begin
      checkEqual(pc, `MIPS_RESET_PC, "pc during reset");
      checkEqual(32'(memWrite), 32'd0, "memWrite during reset");
    end else if (!done) begin
      checkEqual(pc, modelPc, "pc");
      nextPc = stepModel(fetchWord(modelPc), modelPc, modelRegs, modelMem, stEn, stAddr, stData);
      checkEqual(32'(memWrite), 32'(stEn), "memWrite");
      if (stEn) begin
        checkEqual(dataAddr, stAddr, "dataAddr");
        checkEqual(writeData, stData, "writeData");
      end
      modelPc = nextPc;
      done    = (modelPc == 32'(prog.size() * 4)); // Past the last word of the program.
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: the program did not finish within %0d cycles.", cycleLimit);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
+incdir+dv
common/mipsPkg.sv
control/mainDecoder.sv
control/aluDecoder.sv
design/regFile.sv
design/execUnit.sv
design/fetchUnit.sv
design/memStage.sv
design/mipsCore.sv
dv/tbMipsCore.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - common

sources:
  - files:
      - common/mipsPkg.sv
      - control/mainDecoder.sv
      - control/aluDecoder.sv
      - design/regFile.sv
      - design/execUnit.sv
      - design/fetchUnit.sv
      - design/memStage.sv
      - design/mipsCore.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tbMipsCore.sv
